/* hw/tagctrl_pkg.sv */
// ------------------------------
// Tag controller shared types
// Widths, request and response structs, tag store states
// ------------------------------
package tagctrl_pkg;

  // Capability and granule width, equal to the data path width
  localparam int unsigned CapSize       = 128;
  localparam int unsigned AddrWidth     = 32;
  // Byte offset bits inside one granule
  localparam int unsigned GranuleOffset = 4;

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [CapSize-1:0]     data_t;
  typedef logic [CapSize/8-1:0]   strb_t;

  // Single-cycle request from the CPU side
  typedef struct packed {
    addr_t addr;
    data_t wdata;
    strb_t strb;
    logic  we;
    logic  tag;
  } cpu_req_t;

  // Request forwarded to memory, tag bit stripped
  typedef struct packed {
    addr_t addr;
    data_t wdata;
    strb_t strb;
    logic  we;
  } mem_req_t;

  // Read response back to the CPU
  typedef struct packed {
    data_t rdata;
    logic  tag;
  } cpu_rsp_t;

  // Tag store sequencing
  typedef enum logic [0:0] {
    IDLE  = 1'b0,
    FLUSH = 1'b1
  } store_state_e;

endpackage

/* hw/tagctrl_req_unit.sv */
// ------------------------------
// Tag controller request unit
// Forwards CPU requests to memory and drives tag accesses
// ------------------------------
`timescale 1ns/1ps

module tagctrl_req_unit import tagctrl_pkg::*; #(
  parameter addr_t        DramBase    = 32'h8000_0000,
  parameter int unsigned  DramLength  = 4096,
  parameter int unsigned  NumGranules = DramLength / (CapSize / 8),
  localparam int unsigned IdxWidth    = (NumGranules > 1) ? $clog2(NumGranules) : 1
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                cpu_req_valid_i,
  input  cpu_req_t            cpu_req_i,
  output logic                mem_req_valid_o,
  output mem_req_t            mem_req_o,
  output logic                tag_we_o,
  output logic                tag_wbit_o,
  output logic                tag_re_o,
  output logic [IdxWidth-1:0] tag_index_o,
  output logic                tag_in_range_o,
  output logic                push_o,
  input  logic                busy_i
);

  addr_t    offset;
  addr_t    granule;
  logic     in_range;
  logic     full_strb;
  logic     rd_req;

  logic     mem_req_valid_q;
  mem_req_t mem_req_q;
  logic     push_q;
  logic     in_range_q;

  // Window check, addresses below the base wrap to a large offset
  assign offset    = cpu_req_i.addr - DramBase;
  assign granule   = offset >> GranuleOffset;
  assign in_range  = (cpu_req_i.addr >= DramBase) && (offset < DramLength);
  assign full_strb = &cpu_req_i.strb;
  assign rd_req    = cpu_req_valid_i & ~cpu_req_i.we;

  // Partial writes always clear the granule tag
  assign tag_we_o    = cpu_req_valid_i & cpu_req_i.we & in_range;
  assign tag_wbit_o  = cpu_req_i.tag & full_strb;
  assign tag_re_o    = rd_req & in_range;
  assign tag_index_o = granule[IdxWidth-1:0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mem_req_valid_q <= 1'b0;
      push_q          <= 1'b0;
      in_range_q      <= 1'b0;
    end else begin
      mem_req_valid_q <= cpu_req_valid_i;
      // Push lines up with the registered tag store output
      push_q          <= rd_req;
      in_range_q      <= rd_req & in_range;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cpu_req_valid_i) begin
      mem_req_q.addr  <= cpu_req_i.addr;
      mem_req_q.wdata <= cpu_req_i.wdata;
      mem_req_q.strb  <= cpu_req_i.strb;
      mem_req_q.we    <= cpu_req_i.we;
    end
  end

  assign mem_req_valid_o = mem_req_valid_q;
  assign mem_req_o       = mem_req_q;
  assign push_o          = push_q;
  assign tag_in_range_o  = in_range_q;

  // The CPU holds off while the tag store sweeps
  a_no_req_while_busy : assert property (
    @(posedge clk_i) disable iff (reset_i) busy_i |-> !cpu_req_valid_i
  ) else $error("CPU request issued during tag flush");

endmodule

/* hw/tagctrl_tag_store.sv */
// ------------------------------
// Tag store
// One tag bit per granule, registered read, flush sweep
// ------------------------------
`timescale 1ns/1ps

module tagctrl_tag_store import tagctrl_pkg::*; #(
  parameter int unsigned  NumGranules = 256,
  localparam int unsigned IdxWidth    = (NumGranules > 1) ? $clog2(NumGranules) : 1
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                flush_i,
  input  logic                we_i,
  input  logic                wbit_i,
  input  logic                re_i,
  input  logic [IdxWidth-1:0] index_i,
  input  logic                in_range_i,
  output logic                rbit_o,
  output logic                busy_o
);

  logic                tags_q [NumGranules];
  logic                rbit_q;
  store_state_e        state_q;
  logic [IdxWidth-1:0] sweep_q;
  logic                sweep_last;

  assign sweep_last = (sweep_q == IdxWidth'(NumGranules - 1));

  // Reset enters the sweep so every tag starts cleared
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= FLUSH;
      sweep_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          sweep_q <= '0;
          if (flush_i) begin
            state_q <= FLUSH;
          end
        end
        FLUSH: begin
          sweep_q <= sweep_q + 1'b1;
          if (sweep_last) begin
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // Sweep owns the write port while flushing
  always_ff @(posedge clk_i) begin
    if (state_q == FLUSH) begin
      tags_q[sweep_q] <= 1'b0;
    end else if (we_i) begin
      tags_q[index_i] <= wbit_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rbit_q <= tags_q[index_i];
    end
  end

  // Out-of-window reads see tag 0
  assign rbit_o = rbit_q & in_range_i;
  assign busy_o = (state_q == FLUSH);

  a_no_write_in_flush : assert property (
    @(posedge clk_i) disable iff (reset_i) (state_q == FLUSH) |-> !we_i
  ) else $error("Tag write during flush sweep");

endmodule

/* hw/tagctrl_desc_fifo.sv */
// ------------------------------
// Read descriptor FIFO
// Holds looked-up tags until memory returns the data
// ------------------------------
`timescale 1ns/1ps

module tagctrl_desc_fifo #(
  parameter int unsigned  FifoDepth  = 4,
  localparam int unsigned PtrWidth   = (FifoDepth > 1) ? $clog2(FifoDepth) : 1,
  localparam int unsigned UsageWidth = $clog2(FifoDepth + 1)
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic push_i,
  input  logic tag_i,
  input  logic pop_i,
  output logic tag_o
);

  logic                  tags_q [FifoDepth];
  logic [PtrWidth-1:0]   wr_ptr_q;
  logic [PtrWidth-1:0]   rd_ptr_q;
  logic [UsageWidth-1:0] usage_q;
  logic                  full;
  logic                  empty;

  assign full  = (usage_q == UsageWidth'(FifoDepth));
  assign empty = (usage_q == '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count unchanged
      if (push_i && !pop_i) begin
        usage_q <= usage_q + 1'b1;
      end else if (pop_i && !push_i) begin
        usage_q <= usage_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      tags_q[wr_ptr_q] <= tag_i;
    end
  end

  // Head entry, valid whenever the FIFO is not empty
  assign tag_o = tags_q[rd_ptr_q];

  a_no_push_full : assert property (
    @(posedge clk_i) disable iff (reset_i) full |-> !push_i
  ) else $error("More reads outstanding than the FIFO holds");

  a_no_pop_empty : assert property (
    @(posedge clk_i) disable iff (reset_i) empty |-> !pop_i
  ) else $error("Memory response without an outstanding read");

endmodule

/* hw/tagctrl_resp_unit.sv */
// ------------------------------
// Tag controller response unit
// Joins memory read data with its queued tag
// ------------------------------
`timescale 1ns/1ps

module tagctrl_resp_unit import tagctrl_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     mem_rsp_valid_i,
  input  data_t    mem_rsp_data_i,
  input  logic     fifo_tag_i,
  output logic     fifo_pop_o,
  output logic     cpu_rsp_valid_o,
  output cpu_rsp_t cpu_rsp_o
);

  logic     rsp_valid_q;
  cpu_rsp_t rsp_q;

  // Memory answers in order, so the FIFO head belongs to this beat
  assign fifo_pop_o = mem_rsp_valid_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= mem_rsp_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_rsp_valid_i) begin
      rsp_q.rdata <= mem_rsp_data_i;
      rsp_q.tag   <= fifo_tag_i;
    end
  end

  assign cpu_rsp_valid_o = rsp_valid_q;
  assign cpu_rsp_o       = rsp_q;

endmodule

/* hw/tagctrl_top.sv */
// ------------------------------
// Capability tag controller top
// Request, tag store, FIFO and response units
// ------------------------------
`timescale 1ns/1ps

module tagctrl_top import tagctrl_pkg::*; #(
  parameter addr_t        DramBase    = 32'h8000_0000,
  parameter int unsigned  DramLength  = 4096,
  parameter int unsigned  NumGranules = DramLength / (CapSize / 8),
  parameter int unsigned  FifoDepth   = 4,
  localparam int unsigned IdxWidth    = (NumGranules > 1) ? $clog2(NumGranules) : 1
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     cpu_req_valid_i,
  input  cpu_req_t cpu_req_i,
  output logic     mem_req_valid_o,
  output mem_req_t mem_req_o,
  input  logic     mem_rsp_valid_i,
  input  data_t    mem_rsp_data_i,
  output logic     cpu_rsp_valid_o,
  output cpu_rsp_t cpu_rsp_o,
  input  logic     flush_i,
  output logic     busy_o
);

  logic                tag_we;
  logic                tag_wbit;
  logic                tag_re;
  logic [IdxWidth-1:0] tag_index;
  logic                tag_in_range;
  logic                tag_rbit;
  logic                push;
  logic                pop;
  logic                fifo_tag;

  tagctrl_req_unit #(
    .DramBase    (DramBase),
    .DramLength  (DramLength),
    .NumGranules (NumGranules)
  ) i_req_unit (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cpu_req_valid_i (cpu_req_valid_i),
    .cpu_req_i       (cpu_req_i),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .tag_we_o        (tag_we),
    .tag_wbit_o      (tag_wbit),
    .tag_re_o        (tag_re),
    .tag_index_o     (tag_index),
    .tag_in_range_o  (tag_in_range),
    .push_o          (push),
    .busy_i          (busy_o)
  );

  tagctrl_tag_store #(
    .NumGranules (NumGranules)
  ) i_tag_store (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .flush_i    (flush_i),
    .we_i       (tag_we),
    .wbit_i     (tag_wbit),
    .re_i       (tag_re),
    .index_i    (tag_index),
    .in_range_i (tag_in_range),
    .rbit_o     (tag_rbit),
    .busy_o     (busy_o)
  );

  // In-flight read tags, one entry per outstanding read
  tagctrl_desc_fifo #(
    .FifoDepth (FifoDepth)
  ) i_desc_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (push),
    .tag_i   (tag_rbit),
    .pop_i   (pop),
    .tag_o   (fifo_tag)
  );

  tagctrl_resp_unit i_resp_unit (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_data_i  (mem_rsp_data_i),
    .fifo_tag_i      (fifo_tag),
    .fifo_pop_o      (pop),
    .cpu_rsp_valid_o (cpu_rsp_valid_o),
    .cpu_rsp_o       (cpu_rsp_o)
  );

endmodule

/* tests/tagctrl_mem_model.sv */
// ------------------------------
// Behavioural memory for the tag controller testbench
// In-order reads with random latency
// ------------------------------
`timescale 1ns/1ps

module tagctrl_mem_model import tagctrl_pkg::*; #(
  parameter int unsigned Seed = 32'hddf4
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     mem_req_valid_i,
  input  mem_req_t mem_req_i,
  output logic     mem_rsp_valid_o,
  output data_t    mem_rsp_data_o
);

  data_t       mem [addr_t];
  data_t       rd_data_q [$];
  int unsigned rd_due_q [$];
  int unsigned cycle;
  int unsigned last_due;
  int unsigned due;
  addr_t       line_addr;

  // Unwritten granules read back their own aligned address
  function automatic data_t read_line(input addr_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return {4{a}};
  endfunction

  function automatic data_t merge_bytes(input data_t old_d, input data_t new_d,
                                        input strb_t strb);
    data_t res;
    res = old_d;
    for (int i = 0; i < CapSize / 8; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_d[8*i +: 8];
      end
    end
    return res;
  endfunction

  // Runs on the falling edge, where DUT outputs are settled
  initial begin
    void'($urandom(Seed));
    mem_rsp_valid_o = 1'b0;
    mem_rsp_data_o  = '0;
    cycle           = 0;
    last_due        = 0;
    forever begin
      @(negedge clk_i);
      cycle++;
      mem_rsp_valid_o = 1'b0;
      if (reset_i) begin
        rd_data_q.delete();
        rd_due_q.delete();
      end else begin
        if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
          mem_rsp_valid_o = 1'b1;
          mem_rsp_data_o  = rd_data_q.pop_front();
          void'(rd_due_q.pop_front());
        end
        if (mem_req_valid_i) begin
          line_addr = {mem_req_i.addr[AddrWidth-1:GranuleOffset], GranuleOffset'(0)};
          if (mem_req_i.we) begin
            mem[line_addr] = merge_bytes(read_line(line_addr), mem_req_i.wdata,
                                         mem_req_i.strb);
          end else begin
            // 1 to 4 cycles, never overtaking an older read
            due = cycle + ($urandom % 4) + 1;
            if (due <= last_due) begin
              due = last_due + 1;
            end
            last_due = due;
            rd_data_q.push_back(read_line(line_addr));
            rd_due_q.push_back(due);
          end
        end
      end
    end
  end

endmodule

/* tests/tagctrl_tb.sv */
// ------------------------------
// Tag controller testbench
// Vector driven, in-order response checks
// ------------------------------
`timescale 1ns/1ps

module tagctrl_tb import tagctrl_pkg::*; ();

  localparam addr_t       DramBase    = 32'h8000_0000;
  localparam int unsigned DramLength  = 4096;
  localparam int unsigned NumGranules = DramLength / (CapSize / 8);
  localparam int unsigned FifoDepth   = 4;
  localparam int unsigned Seed        = 32'hddf4;

  typedef struct packed {
    logic [7:0] op;
    addr_t      addr;
    data_t      wdata;
    strb_t      strb;
    logic       tag;
    data_t      exp_data;
    logic       exp_tag;
  } vec_t;

  logic     clk_i = 1'b0;
  logic     reset_i;
  logic     cpu_req_valid_i;
  cpu_req_t cpu_req_i;
  logic     mem_req_valid_o;
  mem_req_t mem_req_o;
  logic     mem_rsp_valid_i;
  data_t    mem_rsp_data_i;
  logic     cpu_rsp_valid_o;
  cpu_rsp_t cpu_rsp_o;
  logic     flush_i;
  logic     busy_o;

  vec_t     vecs [$];
  cpu_rsp_t exp_q [$];
  cpu_rsp_t want;
  int       data_errors;
  int       tag_errors;
  int       other_errors;
  int       reads_issued;
  int       rsp_count;
  bit       vectors_loaded;

  // Request and memory beat seen at the last rising edge
  logic     fwd_valid;
  mem_req_t fwd_req;
  logic     rsp_due;

  always #50 clk_i = ~clk_i;

  tagctrl_top #(
    .DramBase    (DramBase),
    .DramLength  (DramLength),
    .NumGranules (NumGranules),
    .FifoDepth   (FifoDepth)
  ) dut (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cpu_req_valid_i (cpu_req_valid_i),
    .cpu_req_i       (cpu_req_i),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_data_i  (mem_rsp_data_i),
    .cpu_rsp_valid_o (cpu_rsp_valid_o),
    .cpu_rsp_o       (cpu_rsp_o),
    .flush_i         (flush_i),
    .busy_o          (busy_o)
  );

  tagctrl_mem_model #(
    .Seed (Seed)
  ) i_mem (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_req_i       (mem_req_o),
    .mem_rsp_valid_o (mem_rsp_valid_i),
    .mem_rsp_data_o  (mem_rsp_data_i)
  );

  // Vector columns are op addr wdata strb tag exp_data exp_tag in hex
  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    string       op_s;
    logic [31:0] a;
    logic [31:0] s;
    logic [31:0] t;
    logic [31:0] et;
    data_t       d;
    data_t       ed;
    vec_t        v;
    fd = $fopen("tests/tagctrl_vectors.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("Could not open the vector file");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %h %h %h %h %h %h", op_s, a, d, s, t, ed, et);
      if (n != 7) begin
        other_errors++;
        $display("Malformed vector line: %s", line);
        continue;
      end
      v.op       = op_s[0];
      v.addr     = a;
      v.wdata    = d;
      v.strb     = s[CapSize/8-1:0];
      v.tag      = t[0];
      v.exp_data = ed;
      v.exp_tag  = et[0];
      vecs.push_back(v);
    end
    $fclose(fd);
  endtask

  // Strobe flush and time the sweep on busy_o
  task automatic run_flush();
    int cnt;
    cnt             = 0;
    cpu_req_valid_i = 1'b0;
    flush_i         = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    assert (busy_o) else begin
      other_errors++;
      $display("busy_o did not rise the cycle after the flush strobe");
    end
    while (busy_o) begin
      cnt++;
      @(negedge clk_i);
    end
    assert (cnt == NumGranules) else begin
      other_errors++;
      $display("FAIL busy_o cycles expected %h got %h", NumGranules, cnt);
    end
  endtask

  // Drives one vector for a single cycle on the falling edge
  task automatic apply_vector(input vec_t v);
    cpu_rsp_t exp_rsp;
    if (v.op == "F") begin
      run_flush();
      return;
    end
    if (v.op != "W" && v.op != "R") begin
      other_errors++;
      $display("Unknown vector opcode %s", v.op);
      return;
    end
    // Never exceed the descriptor FIFO depth
    while (v.op == "R" && (reads_issued - rsp_count) >= FifoDepth) begin
      cpu_req_valid_i = 1'b0;
      @(negedge clk_i);
    end
    cpu_req_valid_i    = 1'b1;
    cpu_req_i.addr     = v.addr;
    cpu_req_i.wdata    = v.wdata;
    cpu_req_i.strb     = v.strb;
    cpu_req_i.we       = (v.op == "W");
    cpu_req_i.tag      = v.tag;
    if (v.op == "R") begin
      exp_rsp.rdata = v.exp_data;
      exp_rsp.tag   = v.exp_tag;
      exp_q.push_back(exp_rsp);
      reads_issued++;
    end
    @(negedge clk_i);
  endtask

  task automatic print_error_counts();
    $display("Errors: data %0d, tag %0d, other %0d", data_errors, tag_errors, other_errors);
  endtask

  // Inputs are stable here since they change on the falling edge
  always @(posedge clk_i) begin
    fwd_valid     <= cpu_req_valid_i;
    fwd_req.addr  <= cpu_req_i.addr;
    fwd_req.wdata <= cpu_req_i.wdata;
    fwd_req.strb  <= cpu_req_i.strb;
    fwd_req.we    <= cpu_req_i.we;
    rsp_due       <= mem_rsp_valid_i;
  end

  // Memory request and CPU response each lag their source by one cycle
  always @(negedge clk_i) begin
    if (!reset_i) begin
      assert (mem_req_valid_o == fwd_valid) else begin
        other_errors++;
        $display("FAIL mem_req_valid_o expected %h got %h", fwd_valid, mem_req_valid_o);
      end
      if (fwd_valid) begin
        assert (mem_req_o == fwd_req) else begin
          other_errors++;
          $display("FAIL mem_req_o expected %h got %h", fwd_req, mem_req_o);
        end
      end
      assert (cpu_rsp_valid_o == rsp_due) else begin
        other_errors++;
        $display("FAIL cpu_rsp_valid_o expected %h got %h", rsp_due, cpu_rsp_valid_o);
      end
    end
  end

  // Responses must come back in request order
  always @(negedge clk_i) begin
    if (!reset_i && cpu_rsp_valid_o) begin
      rsp_count++;
      assert (exp_q.size() > 0) else begin
        other_errors++;
        $display("CPU response arrived with no read outstanding");
      end
      if (exp_q.size() > 0) begin
        want = exp_q.pop_front();
        assert (cpu_rsp_o.rdata == want.rdata) else begin
          data_errors++;
          $display("FAIL cpu_rsp_o.rdata expected %h got %h", want.rdata, cpu_rsp_o.rdata);
        end
        assert (cpu_rsp_o.tag == want.tag) else begin
          tag_errors++;
          $display("FAIL cpu_rsp_o.tag expected %h got %h", want.tag, cpu_rsp_o.tag);
        end
      end
    end
  end

  initial begin
    reset_i         = 1'b1;
    cpu_req_valid_i = 1'b0;
    cpu_req_i       = '0;
    flush_i         = 1'b0;
    data_errors     = 0;
    tag_errors      = 0;
    other_errors    = 0;
    reads_issued    = 0;
    rsp_count       = 0;
    load_vectors();
    vectors_loaded = 1'b1;
    repeat (5) @(negedge clk_i);
    reset_i = 1'b0;
    assert (!mem_req_valid_o && !cpu_rsp_valid_o) else begin
      other_errors++;
      $display("Valid outputs not low after reset");
    end
    // Reset starts a sweep that clears every tag
    while (busy_o) @(negedge clk_i);
    foreach (vecs[i]) begin
      apply_vector(vecs[i]);
    end
    cpu_req_valid_i = 1'b0;
    while (exp_q.size() > 0) @(negedge clk_i);
    repeat (4) @(negedge clk_i);
    print_error_counts();
    if (data_errors + tag_errors + other_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    wait (vectors_loaded);
    repeat (vecs.size() * 20 + 2 * NumGranules) @(posedge clk_i);
    $display("Watchdog expired with %0d reads still outstanding", exp_q.size());
    print_error_counts();
    $display("Something failed");
    $finish;
  end

endmodule

/* tests/tagctrl_vectors.txt */
# op addr wdata strb tag exp_data exp_tag (hex), op W write, R read, F flush
# exp_data and exp_tag apply to reads only, unused fields are 0
# Full-strobe tagged write, then read back with tag 1
W 80000100 0123456789abcdeffedcba9876543210 ffff 1 0 0
R 80000100 0 0 0 0123456789abcdeffedcba9876543210 1
# Partial write clears the tag, data merged
W 80000100 aaaaaaaaaaaaaaaaaaaaaaaa11223344 000f 1 0 0
R 80000100 0 0 0 0123456789abcdeffedcba9811223344 0
# Outside the window, below and just past the end
W 40000000 0badc0de0badc0de0badc0de0badc0de ffff 1 0 0
R 40000000 0 0 0 0badc0de0badc0de0badc0de0badc0de 0
W 80001000 5555aaaa5555aaaa5555aaaa5555aaaa ffff 1 0 0
R 80001000 0 0 0 5555aaaa5555aaaa5555aaaa5555aaaa 0
# Last granule of the window
W 80000ff0 f00df00df00df00df00df00df00df00d ffff 1 0 0
R 80000ff0 0 0 0 f00df00df00df00df00df00df00df00d 1
# Back-to-back reads with mixed tags
W 80000200 b0b1b2b3b4b5b6b7b8b9babbbcbdbebf ffff 1 0 0
W 80000300 c0c1c2c3c4c5c6c7c8c9cacbcccdcecf ffff 0 0 0
W 80000400 d0d1d2d3d4d5d6d7d8d9dadbdcdddedf ffff 1 0 0
W 80000500 e0e1e2e3e4e5e6e7e8e9eaebecedeeef ffff 1 0 0
R 80000200 0 0 0 b0b1b2b3b4b5b6b7b8b9babbbcbdbebf 1
R 80000300 0 0 0 c0c1c2c3c4c5c6c7c8c9cacbcccdcecf 0
R 80000400 0 0 0 d0d1d2d3d4d5d6d7d8d9dadbdcdddedf 1
R 80000500 0 0 0 e0e1e2e3e4e5e6e7e8e9eaebecedeeef 1
R 80000500 0 0 0 e0e1e2e3e4e5e6e7e8e9eaebecedeeef 1
R 80000400 0 0 0 d0d1d2d3d4d5d6d7d8d9dadbdcdddedf 1
R 80000300 0 0 0 c0c1c2c3c4c5c6c7c8c9cacbcccdcecf 0
R 80000200 0 0 0 b0b1b2b3b4b5b6b7b8b9babbbcbdbebf 1
# Flush clears all tags, data stays
F 0 0 0 0 0 0
R 80000200 0 0 0 b0b1b2b3b4b5b6b7b8b9babbbcbdbebf 0
R 80000400 0 0 0 d0d1d2d3d4d5d6d7d8d9dadbdcdddedf 0
R 80000ff0 0 0 0 f00df00df00df00df00df00df00df00d 0
R 80000100 0 0 0 0123456789abcdeffedcba9811223344 0
# Tagging works again after the flush
W 80000600 600d600d600d600d600d600d600d600d ffff 1 0 0
R 80000600 0 0 0 600d600d600d600d600d600d600d600d 1

/* filelist.f */
hw/tagctrl_pkg.sv
hw/tagctrl_req_unit.sv
hw/tagctrl_tag_store.sv
hw/tagctrl_desc_fifo.sv
hw/tagctrl_resp_unit.sv
hw/tagctrl_top.sv
tests/tagctrl_mem_model.sv
tests/tagctrl_tb.sv

/* Bender.yml */
package:
  name: tagctrl

sources:
  - hw/tagctrl_pkg.sv
  - hw/tagctrl_req_unit.sv
  - hw/tagctrl_tag_store.sv
  - hw/tagctrl_desc_fifo.sv
  - hw/tagctrl_resp_unit.sv
  - hw/tagctrl_top.sv
  - target: test
    files:
      - tests/tagctrl_mem_model.sv
      - tests/tagctrl_tb.sv
